//--- Makefile
TOP := memSubsystem_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -Mdir obj_dir -f flist.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/memSubsystem_assert.sv
// protocol checks on the subsystem boundary
module memSubsystem_assert (
  input logic             _OE,
  input logic             rstN,
  input mem_pkg::memReq_t req,
  input mem_pkg::memRsp_t rsp
);

  timeunit 1ns;
  timeprecision 1ps;

  // a response is a read or a collision, never both
  property noValidWithCollide;
    @(posedge _OE) disable iff (!rstN)
      !(rsp.valid && rsp.collide);
  endproperty

  // a read-only strobe always answers in the next cycle
  property readGivesValid;
    @(posedge _OE) disable iff (!rstN)
      (req.rdStrobe && !req.wrStrobe) |=> rsp.valid;
  endproperty

  // response flags come out of reset quiet
  property quietAfterReset;
    @(posedge _OE)
      !rstN |=> (!rsp.valid && !rsp.collide && !rsp.uninit);
  endproperty

  noValidWithCollideA : assert property (noValidWithCollide)
    else $error("rsp.valid and rsp.collide high in the same cycle");

  readGivesValidA : assert property (readGivesValid)
    else $error("read strobe not followed by rsp.valid");

  quietAfterResetA : assert property (quietAfterReset)
    else $error("response flag high in the cycle after reset");

endmodule

bind memSubsystem memSubsystem_assert memSubsystem_assert_i (
  ._OE  (_OE),
  .rstN (rstN),
  .req  (req),
  .rsp  (rsp)
);

//--- bench/memSubsystem_tb.sv
`include "mem_cfg.svh"

module memSubsystem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PULSE_TIMEOUT = 10;
  localparam logic [`MEM_ADDR_W-1:0] HALF = 12'h800;

  logic             _OE;
  logic             rstN;
  mem_pkg::memReq_t req;
  mem_pkg::memRsp_t rsp;

  // reference model of the whole address space
  logic [`MEM_DATA_W-1:0] refMem [`MEM_DEPTH];
  bit                     refWritten [`MEM_DEPTH];

  int     errorCount = 0;
  integer seed = 32'he48;

  memSubsystem memSubsystem_i (
    ._OE  (_OE),
    .rstN (rstN),
    .req  (req),
    .rsp  (rsp)
  );

  initial begin
    _OE = 1'b0;
    forever #2 _OE = ~_OE;
  end

  // the op a response stands for, as seen from outside
  function automatic mem_pkg::memOp_e rspToOp(input mem_pkg::memRsp_t r);
    if (r.collide) begin
      return mem_pkg::opCollide;
    end else if (r.valid) begin
      return mem_pkg::opRead;
    end
    return mem_pkg::opIdle;
  endfunction

  function automatic mem_pkg::memRsp_t expectRead(input logic [`MEM_ADDR_W-1:0] addr);
    mem_pkg::memRsp_t e;
    e.rdData  = refMem[addr];
    e.valid   = 1'b1;
    e.uninit  = !refWritten[addr];
    e.collide = 1'b0;
    return e;
  endfunction

  task automatic checkRsp(input mem_pkg::memRsp_t got, input mem_pkg::memRsp_t exp,
                          input string what);
    logic dataOk;
    // data of an unwritten word is don't care
    dataOk = !exp.valid || exp.uninit || (got.rdData === exp.rdData);
    if (got.valid !== exp.valid || got.collide !== exp.collide ||
        got.uninit !== exp.uninit || !dataOk) begin
      errorCount++;
      $display("error @%0t: %s rsp got data=%h v=%b u=%b c=%b", $time, what,
               got.rdData, got.valid, got.uninit, got.collide);
      $display("error @%0t: %s rsp expected data=%h v=%b u=%b c=%b", $time, what,
               exp.rdData, exp.valid, exp.uninit, exp.collide);
    end
  endtask

  task automatic checkOp(input mem_pkg::memOp_e got, input mem_pkg::memOp_e exp,
                         input string what);
    if (got !== exp) begin
      errorCount++;
      $display("error @%0t: %s op got %s, expected %s", $time, what,
               got.name(), exp.name());
    end
  endtask

  task automatic idleReq();
    req = '0;
  endtask

  task automatic driveReq(input logic [`MEM_ADDR_W-1:0] addr,
                          input logic [`MEM_DATA_W-1:0] data,
                          input logic rd, input logic wr);
    req.addr     = addr;
    req.wrData   = data;
    req.rdStrobe = rd;
    req.wrStrobe = wr;
  endtask

  // wait on falling edges for a valid or collide pulse
  task automatic waitPulse(output int cycles, output bit found);
    found  = 1'b0;
    cycles = 0;
    while (!found && cycles < PULSE_TIMEOUT) begin
      @(negedge _OE);
      cycles++;
      if (rsp.valid || rsp.collide) begin
        found = 1'b1;
      end else begin
        idleReq();
      end
    end
    if (!found) begin
      errorCount++;
      $display("no response pulse arrived within %0d cycles", PULSE_TIMEOUT);
      $display("errors: %0d", errorCount);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  endtask

  // access tasks start and end on a falling edge,
  // so consecutive calls hit consecutive rising edges
  task automatic writeWord(input logic [`MEM_ADDR_W-1:0] addr,
                           input logic [`MEM_DATA_W-1:0] data);
    driveReq(addr, data, 1'b0, 1'b1);
    refMem[addr]     = data;
    refWritten[addr] = 1'b1;
    @(negedge _OE);
    // a plain write answers with no flag at all
    checkOp(rspToOp(rsp), mem_pkg::opIdle, "write");
    idleReq();
  endtask

  task automatic readWord(input logic [`MEM_ADDR_W-1:0] addr);
    mem_pkg::memRsp_t exp;
    int               cycles;
    bit               found;
    driveReq(addr, '0, 1'b1, 1'b0);
    exp = expectRead(addr);
    waitPulse(cycles, found);
    if (found) begin
      if (cycles != 1) begin
        errorCount++;
        $display("error @%0t: read of %h answered after %0d cycles, expected 1",
                 $time, addr, cycles);
      end
      checkOp(rspToOp(rsp), mem_pkg::opRead, "read");
      checkRsp(rsp, exp, "read");
    end
    idleReq();
  endtask

  task automatic collideWord(input logic [`MEM_ADDR_W-1:0] addr,
                             input logic [`MEM_DATA_W-1:0] data);
    mem_pkg::memRsp_t exp;
    int               cycles;
    bit               found;
    driveReq(addr, data, 1'b1, 1'b1);
    // write wins
    refMem[addr]     = data;
    refWritten[addr] = 1'b1;
    exp = '0;
    exp.collide = 1'b1;
    waitPulse(cycles, found);
    if (found) begin
      if (cycles != 1) begin
        errorCount++;
        $display("error @%0t: collision at %h answered after %0d cycles, expected 1",
                 $time, addr, cycles);
      end
      checkOp(rspToOp(rsp), mem_pkg::opCollide, "collide");
      checkRsp(rsp, exp, "collide");
    end
    idleReq();
  endtask

  task automatic idleCycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge _OE);
      checkOp(rspToOp(rsp), mem_pkg::opIdle, "idle");
    end
  endtask

  task automatic afterResetIdle();
    idleCycles(8);
    readWord(12'h000);
    readWord(12'h7ff);
    readWord(12'h800);
    readWord(12'hfff);
  endtask

  task automatic writeThenRead();
    writeWord(12'h010, 8'h5a);
    readWord(12'h010);
    writeWord(12'h810, 8'ha5);
    readWord(12'h810);
  endtask

  task automatic bankSplit();
    logic [`MEM_ADDR_W-1:0] addrA;
    addrA = 12'h123;
    writeWord(addrA, 8'h3c);
    writeWord(addrA + HALF, 8'hc3);
    readWord(addrA);
    readWord(addrA + HALF);
  endtask

  task automatic backToBackReads();
    logic [`MEM_ADDR_W-1:0] addrs [4];
    mem_pkg::memRsp_t       expQ [$];
    mem_pkg::memRsp_t       exp;
    int                     cycles;
    bit                     found;
    addrs = '{12'h020, 12'h821, 12'h022, 12'h823};
    // last address stays unwritten
    writeWord(addrs[0], 8'h11);
    writeWord(addrs[1], 8'h22);
    writeWord(addrs[2], 8'h33);
    driveReq(addrs[0], '0, 1'b1, 1'b0);
    expQ.push_back(expectRead(addrs[0]));
    for (int i = 1; i <= 4; i++) begin
      waitPulse(cycles, found);
      if (!found) begin
        return;
      end
      if (cycles != 1) begin
        errorCount++;
        $display("error @%0t: burst read %0d answered after %0d cycles, expected 1",
                 $time, i - 1, cycles);
      end
      exp = expQ.pop_front();
      checkOp(rspToOp(rsp), mem_pkg::opRead, "burst read");
      checkRsp(rsp, exp, "burst read");
      if (i < 4) begin
        driveReq(addrs[i], '0, 1'b1, 1'b0);
        expQ.push_back(expectRead(addrs[i]));
      end else begin
        idleReq();
      end
    end
  endtask

  task automatic writeWinsCollision();
    collideWord(12'h345, 8'h77);
    readWord(12'h345);
    writeWord(12'h946, 8'h01);
    collideWord(12'h946, 8'hfe);
    readWord(12'h946);
  endtask

  task automatic randomBurst();
    logic [31:0] r;
    logic [31:0] d;
    for (int i = 0; i < 48; i++) begin
      r = $random(seed);
      d = $random(seed);
      // small pool in both banks so reads hit earlier writes
      if (r[16]) begin
        writeWord(r[`MEM_ADDR_W-1:0] & 12'h80f, d[`MEM_DATA_W-1:0]);
      end else begin
        readWord(r[`MEM_ADDR_W-1:0] & 12'h80f);
      end
    end
  endtask

  initial begin
    rstN = 1'b0;
    idleReq();
    repeat (5) @(negedge _OE);
    rstN = 1'b1;

    afterResetIdle();
    writeThenRead();
    bankSplit();
    backToBackReads();
    writeWinsCollision();
    randomBurst();
    idleCycles(4);

    $display("errors: %0d", errorCount);
    if (errorCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/sramArray.sv
hdl/initTracker.sv
hdl/memDecoder.sv
hdl/memSubsystem.sv
bench/memSubsystem_assert.sv
bench/memSubsystem_tb.sv

//--- hdl/initTracker.sv
`include "mem_cfg.svh"

// tracks which locations have been written since reset
// a read of an unwritten word raises uninit, the RTL form of the
// old uninitialised-value alert
module initTracker (
  input  logic                  _OE,
  input  logic                  rstN,
  input  logic                  markEn,
  input  logic                  checkEn,
  input  logic [`MEM_ADDR_W-1:0] addr,
  output logic                  uninit
);

  // one bit per word over both banks
  logic [`MEM_DEPTH-1:0] written;

  logic wasWritten;

  assign wasWritten = written[addr];

  // mark at the write edge
  always_ff @(posedge _OE) begin
    if (!rstN) begin
      written <= '0;
    end else if (markEn) begin
      written[addr] <= 1'b1;
    end
  end

  // flag is registered alongside the bank read word so both
  // reach the decoder in the same cycle

  // a check never shares a cycle with a mark of the same word,
  // collisions only mark
  always_ff @(posedge _OE) begin
    if (!rstN) begin
      uninit <= 1'b0;
    end else begin
      uninit <= checkEn && !wasWritten;
    end
  end

endmodule

//--- hdl/memDecoder.sv
`include "mem_cfg.svh"

// strobe decode, bank steering and response build
module memDecoder (
  input  logic                   _OE,
  input  logic                   rstN,
  input  mem_pkg::memReq_t       req,
  output mem_pkg::bankPort_t     bank0,
  output mem_pkg::bankPort_t     bank1,
  input  logic [`MEM_DATA_W-1:0] rdData0,
  input  logic [`MEM_DATA_W-1:0] rdData1,
  output logic                   markEn,
  output logic                   checkEn,
  input  logic                   uninit,
  output mem_pkg::memRsp_t       rsp
);

  mem_pkg::memOp_e op;
  mem_pkg::memOp_e opQ;

  logic bankSel;
  logic bankSelQ;
  logic doWrite;
  logic doRead;
  logic rdValid;

  // classify the sampled strobes, write wins on a collision
  always_comb begin
    case ({req.wrStrobe, req.rdStrobe})
      2'b01:   op = mem_pkg::opRead;
      2'b10:   op = mem_pkg::opWrite;
      2'b11:   op = mem_pkg::opCollide;
      default: op = mem_pkg::opIdle;
    endcase
  end

  assign doWrite = (op == mem_pkg::opWrite) || (op == mem_pkg::opCollide);
  assign doRead  = (op == mem_pkg::opRead);
  assign bankSel = req.addr[`MEM_ADDR_W-1];

  // both banks see address and data, only the selected one gets an enable
  always_comb begin
    bank0.bankAddr = req.addr[`MEM_BANK_AW-1:0];
    bank0.wrData   = req.wrData;
    bank0.wrEn     = doWrite && !bankSel;
    bank0.rdEn     = doRead && !bankSel;

    bank1.bankAddr = req.addr[`MEM_BANK_AW-1:0];
    bank1.wrData   = req.wrData;
    bank1.wrEn     = doWrite && bankSel;
    bank1.rdEn     = doRead && bankSel;
  end

  // tracker marks every performed write and checks every read
  assign markEn  = doWrite;
  assign checkEn = doRead;

  // response stage, lines up with the bank read register
  always_ff @(posedge _OE) begin
    if (!rstN) begin
      opQ      <= mem_pkg::opIdle;
      bankSelQ <= 1'b0;
    end else begin
      opQ      <= op;
      bankSelQ <= bankSel;
    end
  end

  assign rdValid = (opQ == mem_pkg::opRead);

  always_comb begin
    rsp.rdData  = bankSelQ ? rdData1 : rdData0;
    rsp.valid   = rdValid;
    rsp.uninit  = rdValid && uninit;
    rsp.collide = (opQ == mem_pkg::opCollide);
  end

endmodule

//--- hdl/memSubsystem.sv
`include "mem_cfg.svh"

// two-bank RAM subsystem
// request in, response out one cycle later
module memSubsystem (
  input  logic             _OE,
  input  logic             rstN,
  input  mem_pkg::memReq_t req,
  output mem_pkg::memRsp_t rsp
);

  mem_pkg::bankPort_t bank0;
  mem_pkg::bankPort_t bank1;

  logic [`MEM_DATA_W-1:0] rdData0;
  logic [`MEM_DATA_W-1:0] rdData1;

  logic markEn;
  logic checkEn;
  logic uninit;

  memDecoder memDecoder_i (
    ._OE     (_OE),
    .rstN    (rstN),
    .req     (req),
    .bank0   (bank0),
    .bank1   (bank1),
    .rdData0 (rdData0),
    .rdData1 (rdData1),
    .markEn  (markEn),
    .checkEn (checkEn),
    .uninit  (uninit),
    .rsp     (rsp)
  );

  // lower half of the address space
  sramArray bank0Ram (
    ._OE    (_OE),
    .port   (bank0),
    .rdData (rdData0)
  );

  // upper half of the address space
  sramArray bank1Ram (
    ._OE    (_OE),
    .port   (bank1),
    .rdData (rdData1)
  );

  // tracker works on the full address so it covers both banks
  initTracker initTracker_i (
    ._OE     (_OE),
    .rstN    (rstN),
    .markEn  (markEn),
    .checkEn (checkEn),
    .addr    (req.addr),
    .uninit  (uninit)
  );

endmodule

//--- hdl/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// one data word
`define MEM_DATA_W 8

// full address, top bit picks the bank
`define MEM_ADDR_W 12

// number of RAM banks behind the decoder
`define MEM_BANKS 2

// address width inside one bank
`define MEM_BANK_AW (`MEM_ADDR_W - 1)

// words per bank and over the whole space
`define MEM_BANK_DEPTH (1 << `MEM_BANK_AW)
`define MEM_DEPTH (`MEM_BANKS * `MEM_BANK_DEPTH)

`endif

//--- hdl/mem_pkg.sv
`include "mem_cfg.svh"

package mem_pkg;

  // decoded operation for one sampled request
  // a collision keeps the write and drops the read
  typedef enum logic [1:0] {
    opIdle    = 2'd0,
    opRead    = 2'd1,
    opWrite   = 2'd2,
    opCollide = 2'd3
  } memOp_e;

  // request from the outside world, strobes are active-high levels
  typedef struct packed {
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] wrData;
    logic                   rdStrobe;
    logic                   wrStrobe;
  } memReq_t;

  // response, every flag is a one-cycle pulse
  typedef struct packed {
    logic [`MEM_DATA_W-1:0] rdData;
    logic                   valid;
    logic                   uninit;
    logic                   collide;
  } memRsp_t;

  // decoder to bank bundle
  typedef struct packed {
    logic [`MEM_BANK_AW-1:0] bankAddr;
    logic [`MEM_DATA_W-1:0]  wrData;
    logic                    wrEn;
    logic                    rdEn;
  } bankPort_t;

endpackage

//--- hdl/sramArray.sv
`include "mem_cfg.svh"

// one clocked RAM bank
// stands in for the 6116/62256 part of the old asynchronous design
module sramArray (
  input  logic                   _OE,
  input  mem_pkg::bankPort_t     port,
  output logic [`MEM_DATA_W-1:0] rdData
);

  // storage, no reset on contents
  logic [`MEM_DATA_W-1:0] mem [`MEM_BANK_DEPTH];

  logic                    doWrite;
  logic                    doRead;
  logic [`MEM_BANK_AW-1:0] wordAddr;

  assign wordAddr = port.bankAddr;

  // write has priority over read, as on the real chip where
  // a low write enable overrides the output enable
  assign doWrite = port.wrEn;
  assign doRead  = port.rdEn && !port.wrEn;

  // write lands at the strobe edge
  always_ff @(posedge _OE) begin
    if (doWrite) begin
      mem[wordAddr] <= port.wrData;
    end
  end

  // registered read, one cycle after rdEn
  // the word holds its old value on any cycle without a read,
  // including a cycle where a write suppressed the read
  always_ff @(posedge _OE) begin
    if (doRead) begin
      rdData <= mem[wordAddr];
    end
  end

endmodule
